// ==== clk_drp_space.sv ====
// mmcm configuration space model on a drp port
// 128 word store, fixed access latency, lock flag after reset release
// any drp write drops the lock and restarts the lock count

`timescale 1ns/1ps
`default_nettype none

module clk_drp_space (
  input  wire                                      up_clk,
  input  wire                                      up_rstn,
  input  wire                                      mmcm_rst,
  input  wire                                      drp_sel,
  input  wire                                      drp_wr,
  input  wire  [up_clkgen_pkg::drp_addr_width-1:0] drp_addr,
  input  wire  [up_clkgen_pkg::drp_data_width-1:0] drp_wdata,
  output logic [up_clkgen_pkg::drp_data_width-1:0] drp_rdata,
  output logic                                     drp_ready,
  output logic                                     drp_locked
);

  // configuration store
  logic [up_clkgen_pkg::drp_data_width-1:0] cfg_mem [0:127];

  // access in flight
  logic [up_clkgen_pkg::drp_cnt_width-1:0]  lat_cnt;
  logic                                     accept;
  logic                                     acc_wr;
  logic [6:0]                               acc_idx;
  logic [up_clkgen_pkg::drp_data_width-1:0] acc_wdata;

  // lock tracking
  logic [up_clkgen_pkg::lock_cnt_width-1:0] lock_cnt;
  logic                                     lock_restart;

  // ****************************************
  // access latency
  // ****************************************

  // selects while busy are dropped
  assign accept = drp_sel & (lat_cnt == '0);

  // ready in the last count cycle
  assign drp_ready = (lat_cnt == up_clkgen_pkg::drp_cnt_width'(1));

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      lat_cnt <= '0;
    end else if (accept) begin
      lat_cnt <= up_clkgen_pkg::drp_cnt_width'(up_clkgen_pkg::drp_latency);
    end else if (lat_cnt != '0) begin
      lat_cnt <= lat_cnt - 1'b1;
    end
  end

  // capture the access, read data taken at select
  // only the low 7 address bits index the store
  always_ff @(posedge up_clk) begin
    if (accept) begin
      acc_wr    <= drp_wr;
      acc_idx   <= drp_addr[6:0];
      acc_wdata <= drp_wdata;
      drp_rdata <= cfg_mem[drp_addr[6:0]];
    end
  end

  // ****************************************
  // store
  // ****************************************

  // write commits with ready, kept through mmcm reset
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      for (int i = 0; i < 128; i++) begin
        cfg_mem[i] <= '0;
      end
    end else if (drp_ready && acc_wr) begin
      cfg_mem[acc_idx] <= acc_wdata;
    end
  end

  // ****************************************
  // lock
  // ****************************************

  // reconfiguration drops lock like a real mmcm
  assign lock_restart = accept & drp_wr;

  // count from reset release, flag after lock_delay cycles
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      lock_cnt   <= '0;
      drp_locked <= 1'b0;
    end else if (mmcm_rst || lock_restart) begin
      lock_cnt   <= '0;
      drp_locked <= 1'b0;
    end else if (!drp_locked) begin
      if (lock_cnt == up_clkgen_pkg::lock_cnt_width'(up_clkgen_pkg::lock_delay - 1)) begin
        drp_locked <= 1'b1;
      end else begin
        lock_cnt <= lock_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== compile.f ====
up_clkgen_pkg.sv
up_clkgen.sv
clk_drp_space.sv
up_clkgen_top.sv
up_clkgen_checker.sv
tb_up_clkgen.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the clock generator testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -j 0 \
  --top-module tb_up_clkgen \
  -f compile.f \
  -o sim_tb

status=0
output=$(./obj_dir/sim_tb +verilator+error+limit+100 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -Fqx '=== PASS ==='; then
  exit 0
fi

echo "simulation did not pass (exit status $status)"
exit 1

// ==== tb_up_clkgen.sv ====
// testbench for the clock generator control core
// bus tasks on the falling edge, lfsr stimulus, value checks,
// cycle timeout and a watch on the bound handshake checker

`timescale 1ns/1ps
`default_nettype none

module tb_up_clkgen;

  localparam int unsigned tb_id = 7;
  // about 80 bus transfers of 2 cycles plus drp polls and three lock waits
  localparam int unsigned timeout_cycles = 2000;
  localparam int unsigned lock_wait = up_clkgen_pkg::lock_delay + 8;

  logic        up_clk;
  logic        up_rstn;
  logic        up_wreq;
  logic [13:0] up_waddr;
  logic [31:0] up_wdata;
  logic        up_rreq;
  logic [13:0] up_raddr;
  logic        up_wack;
  logic [31:0] up_rdata;
  logic        up_rack;
  logic        clk_sel;
  logic        mmcm_rst;

  logic [31:0] lfsr_state;
  int unsigned cycle_count = 0;
  logic [31:0] rdata;
  logic [31:0] rand_word;
  logic [31:0] sel_word;
  logic [31:0] last_cmd;
  logic [11:0] drp_addrs [0:3];
  logic [15:0] drp_words [0:3];
  up_clkgen_pkg::drp_cmd_u cmd;

  up_clkgen_top #(
    .ID (tb_id)
  ) UUT (
    .up_clk   (up_clk),
    .up_rstn  (up_rstn),
    .up_wreq  (up_wreq),
    .up_waddr (up_waddr),
    .up_wdata (up_wdata),
    .up_wack  (up_wack),
    .up_rreq  (up_rreq),
    .up_raddr (up_raddr),
    .up_rdata (up_rdata),
    .up_rack  (up_rack),
    .clk_sel  (clk_sel),
    .mmcm_rst (mmcm_rst)
  );

  initial up_clk = 1'b0;
  always #2 up_clk = ~up_clk;

  // ****************************************
  // helpers
  // ****************************************

  task automatic fail_run();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      fail_run();
    end
  endtask

  // right shift galois lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 32'h80200003;
    end
    return next;
  endfunction

  // one step per bit taken
  task automatic draw_bits(input int unsigned n, output logic [31:0] value);
    value = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [13:0] reg_addr(input logic [7:0] offset);
    return {6'd0, offset};
  endfunction

  task automatic up_write(input logic [13:0] addr, input logic [31:0] data);
    @(negedge up_clk);
    up_wreq  = 1'b1;
    up_waddr = addr;
    up_wdata = data;
    @(negedge up_clk);
    up_wreq = 1'b0;
    while (!up_wack) @(negedge up_clk);
  endtask

  // data taken in the ack cycle
  task automatic up_read(input logic [13:0] addr, output logic [31:0] data);
    @(negedge up_clk);
    up_rreq  = 1'b1;
    up_raddr = addr;
    @(negedge up_clk);
    up_rreq = 1'b0;
    while (!up_rack) @(negedge up_clk);
    data = up_rdata;
  endtask

  // write and read outside block 0 in one cycle, neither may be acked
  task automatic send_foreign_requests(input logic [13:0] waddr, input logic [31:0] wdata,
                                       input logic [13:0] raddr);
    @(negedge up_clk);
    up_wreq  = 1'b1;
    up_waddr = waddr;
    up_wdata = wdata;
    up_rreq  = 1'b1;
    up_raddr = raddr;
    @(negedge up_clk);
    up_wreq = 1'b0;
    up_rreq = 1'b0;
    check_value("foreign write ack", 32'd0, {31'd0, up_wack});
    check_value("foreign read ack", 32'd0, {31'd0, up_rack});
  endtask

  // poll status until busy (bit 16) clears
  task automatic drp_wait_idle(output logic [31:0] status);
    up_read(reg_addr(up_clkgen_pkg::reg_drp_status), status);
    while (status[16]) begin
      up_read(reg_addr(up_clkgen_pkg::reg_drp_status), status);
    end
  endtask

  // ****************************************
  // watchdogs
  // ****************************************

  always @(posedge up_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
      fail_run();
    end
  end

  always @(negedge up_clk) begin
    if (UUT.u_checker.error_count != 0) begin
      $display("a handshake assertion in the checker failed");
      fail_run();
    end
  end

  // ****************************************
  // tests
  // ****************************************

  initial begin
    up_rstn    = 1'b0;
    up_wreq    = 1'b0;
    up_waddr   = '0;
    up_wdata   = '0;
    up_rreq    = 1'b0;
    up_raddr   = '0;
    lfsr_state = 32'h86e2;
    last_cmd   = '0;
    // distinct low 7 bits and one with upper address bits set
    drp_addrs[0] = 12'h008;
    drp_addrs[1] = 12'h013;
    drp_addrs[2] = 12'h0a5;
    drp_addrs[3] = 12'h07f;
    repeat (3) @(posedge up_clk);
    @(negedge up_clk);
    up_rstn = 1'b1;

    // identity and reset state
    check_value("mmcm_rst after reset", 32'd1, {31'd0, mmcm_rst});
    check_value("clk_sel after reset", 32'd1, {31'd0, clk_sel});
    up_read(reg_addr(up_clkgen_pkg::reg_version), rdata);
    check_value("version", up_clkgen_pkg::pcore_version, rdata);
    up_read(reg_addr(up_clkgen_pkg::reg_id), rdata);
    check_value("id", tb_id, rdata);
    for (int i = 0; i < 8; i++) begin
      draw_bits(32, rand_word);
      up_write(reg_addr(up_clkgen_pkg::reg_scratch), rand_word);
      up_read(reg_addr(up_clkgen_pkg::reg_scratch), rdata);
      check_value("scratch", rand_word, rdata);
    end

    // block 1 and 3 requests leave scratch untouched
    send_foreign_requests(14'h0102, ~rand_word, 14'h0310);
    up_read(reg_addr(up_clkgen_pkg::reg_scratch), rdata);
    check_value("scratch after foreign write", rand_word, rdata);

    // mmcm reset release through the two flop stage then lock
    up_write(reg_addr(up_clkgen_pkg::reg_rstn), 32'h3);
    check_value("mmcm_rst before release", 32'd1, {31'd0, mmcm_rst});
    repeat (2) @(negedge up_clk);
    check_value("mmcm_rst released", 32'd0, {31'd0, mmcm_rst});
    up_read(reg_addr(up_clkgen_pkg::reg_rstn), rdata);
    check_value("reset register", 32'h3, rdata);
    up_read(reg_addr(up_clkgen_pkg::reg_locked), rdata);
    check_value("locked early", 32'd0, rdata);
    repeat (lock_wait) @(negedge up_clk);
    up_read(reg_addr(up_clkgen_pkg::reg_locked), rdata);
    check_value("locked", 32'd1, rdata);

    // clock select written both ways and leaving inverted
    draw_bits(1, rand_word);
    for (int i = 0; i < 3; i++) begin
      sel_word = {31'd0, rand_word[0] ^ i[0]};
      up_write(reg_addr(up_clkgen_pkg::reg_clk_sel), sel_word);
      check_value("clk_sel level", {31'd0, ~sel_word[0]}, {31'd0, clk_sel});
      up_read(reg_addr(up_clkgen_pkg::reg_clk_sel), rdata);
      check_value("clk_sel register", sel_word, rdata);
    end

    // drp writes then readback
    for (int i = 0; i < 4; i++) begin
      draw_bits(16, rand_word);
      drp_words[i] = rand_word[15:0];
      cmd.raw = '0;
      cmd.fields.read_not_write = 1'b0;
      cmd.fields.drp_addr = drp_addrs[i];
      cmd.fields.drp_data = drp_words[i];
      up_write(reg_addr(up_clkgen_pkg::reg_drp_cmd), cmd.raw);
      drp_wait_idle(rdata);
    end
    for (int i = 0; i < 4; i++) begin
      cmd.raw = '0;
      cmd.fields.read_not_write = 1'b1;
      cmd.fields.drp_addr = drp_addrs[i];
      up_write(reg_addr(up_clkgen_pkg::reg_drp_cmd), cmd.raw);
      last_cmd = cmd.raw;
      drp_wait_idle(rdata);
      check_value("drp readback", {16'd0, drp_words[i]}, {16'd0, rdata[15:0]});
    end
    up_read(reg_addr(up_clkgen_pkg::reg_drp_cmd), rdata);
    check_value("drp command readback", last_cmd, rdata);

    // reconfiguration drops lock until the count runs again
    repeat (lock_wait) @(negedge up_clk);
    up_read(reg_addr(up_clkgen_pkg::reg_locked), rdata);
    check_value("locked before reconfig", 32'd1, rdata);
    draw_bits(16, rand_word);
    cmd.raw = '0;
    cmd.fields.drp_addr = drp_addrs[0];
    cmd.fields.drp_data = rand_word[15:0];
    up_write(reg_addr(up_clkgen_pkg::reg_drp_cmd), cmd.raw);
    up_read(reg_addr(up_clkgen_pkg::reg_locked), rdata);
    check_value("locked after reconfig", 32'd0, rdata);
    drp_wait_idle(rdata);
    repeat (lock_wait) @(negedge up_clk);
    up_read(reg_addr(up_clkgen_pkg::reg_locked), rdata);
    check_value("relocked", 32'd1, rdata);

    repeat (2) @(negedge up_clk);
    if (UUT.u_checker.error_count == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("a handshake assertion in the checker failed");
      fail_run();
    end
  end

endmodule

`default_nettype wire

// ==== up_clkgen.sv ====
// clock generator register bank
// block 0 decode, scratch, reset and clock select controls,
// indirect drp command port and the two-flop mmcm reset stage

`timescale 1ns/1ps
`default_nettype none

module up_clkgen #(
  parameter int unsigned ID = 0
) (
  // bus interface
  input  wire                                      up_clk,
  input  wire                                      up_rstn,
  input  wire                                      up_wreq,
  input  wire  [up_clkgen_pkg::up_addr_width-1:0]  up_waddr,
  input  wire  [up_clkgen_pkg::up_data_width-1:0]  up_wdata,
  output logic                                     up_wack,
  input  wire                                      up_rreq,
  input  wire  [up_clkgen_pkg::up_addr_width-1:0]  up_raddr,
  output logic [up_clkgen_pkg::up_data_width-1:0]  up_rdata,
  output logic                                     up_rack,

  // drp interface
  output logic                                     drp_sel,
  output logic                                     drp_wr,
  output logic [up_clkgen_pkg::drp_addr_width-1:0] drp_addr,
  output logic [up_clkgen_pkg::drp_data_width-1:0] drp_wdata,
  input  wire  [up_clkgen_pkg::drp_data_width-1:0] drp_rdata,
  input  wire                                      drp_ready,
  input  wire                                      drp_locked,

  // mmcm reset and clock select levels
  output logic                                     mmcm_rst,
  output logic                                     clk_sel
);

  // block qualified requests
  logic wreq_s;
  logic rreq_s;

  // per register write strobes
  logic wr_scratch;
  logic wr_rstn;
  logic wr_clk_sel;
  logic wr_drp_cmd;

  // control registers
  logic [up_clkgen_pkg::up_data_width-1:0]  scratch;
  logic                                     mmcm_resetn;
  logic                                     core_resetn;
  logic                                     clk_sel_q;
  logic                                     drp_status;
  logic                                     mmcm_preset;

  // drp command, incoming and held
  up_clkgen_pkg::drp_cmd_u                  cmd_w;
  up_clkgen_pkg::drp_cmd_u                  cmd_q;
  logic [up_clkgen_pkg::drp_data_width-1:0] drp_rdata_hold;

  // ****************************************
  // block decode
  // ****************************************

  // only block 0 (addr bits 13..8 zero) belongs here
  assign wreq_s = up_wreq & (up_waddr[13:8] == 6'd0);
  assign rreq_s = up_rreq & (up_raddr[13:8] == 6'd0);

  assign wr_scratch = wreq_s & (up_waddr[7:0] == up_clkgen_pkg::reg_scratch);
  assign wr_rstn    = wreq_s & (up_waddr[7:0] == up_clkgen_pkg::reg_rstn);
  assign wr_clk_sel = wreq_s & (up_waddr[7:0] == up_clkgen_pkg::reg_clk_sel);
  assign wr_drp_cmd = wreq_s & (up_waddr[7:0] == up_clkgen_pkg::reg_drp_cmd);

  // write data seen as a drp command
  assign cmd_w.raw = up_wdata;

  // select level leaves inverted
  assign clk_sel = ~clk_sel_q;

  // held command drives the drp address and data
  assign drp_addr  = cmd_q.fields.drp_addr;
  assign drp_wdata = cmd_q.fields.drp_data;

  // ****************************************
  // write path
  // ****************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_wack     <= 1'b0;
      mmcm_resetn <= 1'b0;
      core_resetn <= 1'b0;
      clk_sel_q   <= 1'b0;
    end else begin
      up_wack <= wreq_s;
      // bit 1 mmcm, bit 0 core
      if (wr_rstn) begin
        mmcm_resetn <= up_wdata[1];
        core_resetn <= up_wdata[0];
      end
      if (wr_clk_sel) begin
        clk_sel_q <= up_wdata[0];
      end
    end
  end

  // scratch word, no function beyond readback
  always_ff @(posedge up_clk) begin
    if (wr_scratch) begin
      scratch <= up_wdata;
    end
  end

  // ****************************************
  // drp command issue
  // ****************************************

  // one cycle select, busy until the cycle after ready
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      drp_sel    <= 1'b0;
      drp_wr     <= 1'b0;
      drp_status <= 1'b0;
    end else begin
      drp_sel <= wr_drp_cmd;
      drp_wr  <= wr_drp_cmd & ~cmd_w.fields.read_not_write;
      // a new command wins over a ready in the same cycle
      if (wr_drp_cmd) begin
        drp_status <= 1'b1;
      end else if (drp_ready) begin
        drp_status <= 1'b0;
      end
    end
  end

  // command word held until the next command
  always_ff @(posedge up_clk) begin
    if (wr_drp_cmd) begin
      cmd_q <= cmd_w;
    end
  end

  // last drp read data
  always_ff @(posedge up_clk) begin
    if (drp_ready) begin
      drp_rdata_hold <= drp_rdata;
    end
  end

  // ****************************************
  // read path
  // ****************************************

  // data only in the ack cycle, zero otherwise
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_rack  <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_rack <= rreq_s;
      if (rreq_s) begin
        case (up_raddr[7:0])
          up_clkgen_pkg::reg_version:    up_rdata <= up_clkgen_pkg::pcore_version;
          up_clkgen_pkg::reg_id:         up_rdata <= ID;
          up_clkgen_pkg::reg_scratch:    up_rdata <= scratch;
          up_clkgen_pkg::reg_rstn:       up_rdata <= {30'd0, mmcm_resetn, core_resetn};
          up_clkgen_pkg::reg_clk_sel:    up_rdata <= {31'd0, clk_sel_q};
          up_clkgen_pkg::reg_locked:     up_rdata <= {31'd0, drp_locked};
          up_clkgen_pkg::reg_drp_cmd:    up_rdata <= cmd_q.raw;
          up_clkgen_pkg::reg_drp_status: begin
            up_rdata <= {14'd0, drp_locked, drp_status, drp_rdata_hold};
          end
          default:                       up_rdata <= '0;
        endcase
      end else begin
        up_rdata <= '0;
      end
    end
  end

  // ****************************************
  // mmcm reset stage
  // ****************************************

  // preset by bus reset or a 0 in the mmcm control bit,
  // release reaches mmcm_rst two cycles after the write
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      mmcm_preset <= 1'b1;
      mmcm_rst    <= 1'b1;
    end else begin
      mmcm_preset <= ~mmcm_resetn;
      mmcm_rst    <= mmcm_preset;
    end
  end

endmodule

`default_nettype wire

// ==== up_clkgen_checker.sv ====
// clock generator handshake checker
// concurrent assertions on the processor bus and the drp pulses,
// bound into every up_clkgen_top instance

`timescale 1ns/1ps
`default_nettype none

module up_clkgen_checker (
  input wire                                     up_clk,
  input wire                                     up_rstn,
  input wire                                     up_wreq,
  input wire [up_clkgen_pkg::up_addr_width-1:0]  up_waddr,
  input wire                                     up_wack,
  input wire                                     up_rreq,
  input wire [up_clkgen_pkg::up_addr_width-1:0]  up_raddr,
  input wire [up_clkgen_pkg::up_data_width-1:0]  up_rdata,
  input wire                                     up_rack,
  input wire                                     drp_sel,
  input wire                                     drp_ready,
  input wire                                     drp_busy
);

  // failed assertions so far
  int unsigned error_count = 0;

  // ****************************************
  // processor bus
  // ****************************************

  // block 0 request, ack one cycle later
  a_wack_follows: assert property (@(posedge up_clk) disable iff (!up_rstn)
    (up_wreq && up_waddr[13:8] == 6'd0) |=> up_wack)
    else begin error_count++; $error("write ack missing after a block 0 request"); end

  // no ack without a block 0 request, other blocks never answered
  a_wack_source: assert property (@(posedge up_clk) disable iff (!up_rstn)
    up_wack |-> $past(up_wreq && up_waddr[13:8] == 6'd0))
    else begin error_count++; $error("write ack without a block 0 request"); end

  a_rack_follows: assert property (@(posedge up_clk) disable iff (!up_rstn)
    (up_rreq && up_raddr[13:8] == 6'd0) |=> up_rack)
    else begin error_count++; $error("read ack missing after a block 0 request"); end

  a_rack_source: assert property (@(posedge up_clk) disable iff (!up_rstn)
    up_rack |-> $past(up_rreq && up_raddr[13:8] == 6'd0))
    else begin error_count++; $error("read ack without a block 0 request"); end

  // read data bus quiet outside the ack cycle
  a_rdata_idle: assert property (@(posedge up_clk) disable iff (!up_rstn)
    !up_rack |-> (up_rdata == '0))
    else begin error_count++; $error("read data nonzero outside the ack cycle"); end

  // ****************************************
  // drp pulses
  // ****************************************

  a_sel_pulse: assert property (@(posedge up_clk) disable iff (!up_rstn)
    drp_sel |=> !drp_sel)
    else begin error_count++; $error("drp select longer than one cycle"); end

  // ready exactly drp_latency cycles after select, both ways
  a_ready_after_sel: assert property (@(posedge up_clk) disable iff (!up_rstn)
    $past(drp_sel, up_clkgen_pkg::drp_latency) |-> drp_ready)
    else begin error_count++; $error("drp ready missing after select"); end

  a_ready_source: assert property (@(posedge up_clk) disable iff (!up_rstn)
    drp_ready |-> $past(drp_sel, up_clkgen_pkg::drp_latency))
    else begin error_count++; $error("drp ready without an earlier select"); end

  // busy from select until the cycle after ready
  a_busy_set: assert property (@(posedge up_clk) disable iff (!up_rstn)
    drp_sel |-> drp_busy)
    else begin error_count++; $error("drp busy not set with select"); end

  a_busy_hold: assert property (@(posedge up_clk) disable iff (!up_rstn)
    (drp_busy && !drp_ready) |=> drp_busy)
    else begin error_count++; $error("drp busy dropped before ready"); end

  a_busy_clear: assert property (@(posedge up_clk) disable iff (!up_rstn)
    drp_ready |=> (!drp_busy || drp_sel))
    else begin error_count++; $error("drp busy still set after ready"); end

endmodule

bind up_clkgen_top up_clkgen_checker u_checker (
  .up_clk    (up_clk),
  .up_rstn   (up_rstn),
  .up_wreq   (up_wreq),
  .up_waddr  (up_waddr),
  .up_wack   (up_wack),
  .up_rreq   (up_rreq),
  .up_raddr  (up_raddr),
  .up_rdata  (up_rdata),
  .up_rack   (up_rack),
  .drp_sel   (drp_sel),
  .drp_ready (drp_ready),
  .drp_busy  (i_up_clkgen.drp_status)
);

`default_nettype wire

// ==== up_clkgen_pkg.sv ====
// clock generator control core, shared definitions
// bus and drp widths, register map, drp timing and the drp command word

`default_nettype none

package up_clkgen_pkg;

  // ****************************************
  // bus widths
  // ****************************************

  localparam int unsigned up_addr_width = 14;
  localparam int unsigned up_data_width = 32;

  // mmcm dynamic reconfiguration port
  localparam int unsigned drp_addr_width = 12;
  localparam int unsigned drp_data_width = 16;

  // core version, returned at offset 0x00
  localparam logic [31:0] pcore_version = 32'h00040063;

  // ****************************************
  // register offsets, block 0
  // ****************************************

  localparam logic [7:0] reg_version    = 8'h00;
  localparam logic [7:0] reg_id         = 8'h01;
  localparam logic [7:0] reg_scratch    = 8'h02;
  localparam logic [7:0] reg_rstn       = 8'h10;
  localparam logic [7:0] reg_clk_sel    = 8'h11;
  localparam logic [7:0] reg_locked     = 8'h17;
  localparam logic [7:0] reg_drp_cmd    = 8'h1c;
  localparam logic [7:0] reg_drp_status = 8'h1d;

  // drp select to ready, in cycles
  localparam int unsigned drp_latency = 3;
  localparam int unsigned drp_cnt_width = $clog2(drp_latency + 1);

  // mmcm reset release to lock, in cycles
  localparam int unsigned lock_delay = 16;
  localparam int unsigned lock_cnt_width = $clog2(lock_delay + 1);

  // ****************************************
  // drp command word
  // ****************************************

  // same 32 bits seen whole on readback, split into fields on issue
  typedef union packed {
    logic [up_data_width-1:0] raw;
    struct packed {
      logic [2:0]                rsvd;
      // 1 = read, 0 = write
      logic                      read_not_write;
      logic [drp_addr_width-1:0] drp_addr;
      logic [drp_data_width-1:0] drp_data;
    } fields;
  } drp_cmd_u;

endpackage

`default_nettype wire

// ==== up_clkgen_top.sv ====
// clock generator control core, top level
// register bank driving the mmcm configuration space model

`timescale 1ns/1ps
`default_nettype none

module up_clkgen_top #(
  parameter int unsigned ID = 0
) (
  input  wire                                      up_clk,
  input  wire                                      up_rstn,
  input  wire                                      up_wreq,
  input  wire  [up_clkgen_pkg::up_addr_width-1:0]  up_waddr,
  input  wire  [up_clkgen_pkg::up_data_width-1:0]  up_wdata,
  output logic                                     up_wack,
  input  wire                                      up_rreq,
  input  wire  [up_clkgen_pkg::up_addr_width-1:0]  up_raddr,
  output logic [up_clkgen_pkg::up_data_width-1:0]  up_rdata,
  output logic                                     up_rack,
  output logic                                     clk_sel,
  output logic                                     mmcm_rst
);

  // drp link
  logic                                     drp_sel;
  logic                                     drp_wr;
  logic [up_clkgen_pkg::drp_addr_width-1:0] drp_addr;
  logic [up_clkgen_pkg::drp_data_width-1:0] drp_wdata;
  logic [up_clkgen_pkg::drp_data_width-1:0] drp_rdata;
  logic                                     drp_ready;
  logic                                     drp_locked;

  // register bank
  up_clkgen #(
    .ID (ID)
  ) i_up_clkgen (
    .up_clk     (up_clk),
    .up_rstn    (up_rstn),
    .up_wreq    (up_wreq),
    .up_waddr   (up_waddr),
    .up_wdata   (up_wdata),
    .up_wack    (up_wack),
    .up_rreq    (up_rreq),
    .up_raddr   (up_raddr),
    .up_rdata   (up_rdata),
    .up_rack    (up_rack),
    .drp_sel    (drp_sel),
    .drp_wr     (drp_wr),
    .drp_addr   (drp_addr),
    .drp_wdata  (drp_wdata),
    .drp_rdata  (drp_rdata),
    .drp_ready  (drp_ready),
    .drp_locked (drp_locked),
    .mmcm_rst   (mmcm_rst),
    .clk_sel    (clk_sel)
  );

  // mmcm stand-in
  clk_drp_space i_drp_space (
    .up_clk     (up_clk),
    .up_rstn    (up_rstn),
    .mmcm_rst   (mmcm_rst),
    .drp_sel    (drp_sel),
    .drp_wr     (drp_wr),
    .drp_addr   (drp_addr),
    .drp_wdata  (drp_wdata),
    .drp_rdata  (drp_rdata),
    .drp_ready  (drp_ready),
    .drp_locked (drp_locked)
  );

endmodule

`default_nettype wire
